//--- build.f
+incdir+tests
logic/nes_input_pkg.sv
logic/nes_mem_pkg.sv
logic/pad_mapper.sv
logic/joypad_port.sv
logic/loader_write_stage.sv
logic/backup_ram_ctrl.sv
logic/nes_io_top.sv
tests/tb_nes_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the nes io testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_nes_io \
	-f build.f --Mdir "$BUILD_DIR" -o tb_nes_io
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_nes_io" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG_FILE"; then
	echo "result: pass"
	exit 0
fi

echo "result: fail"
exit 1

//--- tests/tb_nes_io_checks.svh
// ============================================================
// testbench checks and watchdog
// ============================================================
`ifndef TB_NES_IO_CHECKS_SVH
`define TB_NES_IO_CHECKS_SVH

	int unsigned error_count = 0;
	int unsigned errors_at_start = 0;
	int unsigned tests_run = 0;
	int unsigned tests_with_errors = 0;
	string       test_name = "";

	// turbo wait dominates, the other tests need far less than their share
	localparam longint WATCHDOG_NS = (longint'(TURBO_WAIT) + 2000 * NUM_TESTS) * CLK_PERIOD;

	task automatic report_error(input string what);
		$display("ERROR in %s: %s", test_name, what);
		error_count++;
	endtask

	task automatic check_pad(input string what, input pad_data_t exp, input pad_data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_mem(input string what, input mem_addr_t exp_addr,
			input mem_byte_t exp_data, input mem_addr_t act_addr, input mem_byte_t act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("CHECK FAILED %s: %s expected %h/%h actual %h/%h", test_name, what,
				exp_addr, exp_data, act_addr, act_data);
			error_count++;
		end
	endtask

	task automatic check_lba(input string what, input sd_lba_t exp, input sd_lba_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_buf_addr(input string what, input sd_buff_addr_t exp,
			input sd_buff_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: %s expected %b actual %b", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_with_errors++;
			$display("test %s: %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

`endif

//--- tests/tb_nes_io.sv
// ============================================================
// nes io glue testbench
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module tb_nes_io;
	import nes_input_pkg::*;
	import nes_mem_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS  = 6;
	localparam int TURBO_WAIT = 1 << (TURBO_BITS - 1);

	logic          clk = 1'b0;
	logic          reset_nes;
	logic          joy_swap, joypad_strobe, downloading, loader_busy, loader_write;
	logic          cpu_read, cpu_write, mem_we, mem_oe;
	logic          img_mounted, bk_save, sd_ack, sd_buff_wr, sd_buff_rd;
	logic          sd_rd, sd_wr, bk_ena, sram_req, sram_we, model_req;
	logic [1:0]    joypad_clock;
	joy_word_t     joy_a, joy_b;
	pad_data_t     joypad1_data, joypad2_data;
	mem_addr_t     loader_addr, cpu_addr, mem_addr;
	mem_byte_t     loader_data, cpu_dout, mem_din;
	nes_phase_t    nes_ce;
	img_size_t     img_size;
	sd_buff_addr_t sd_buff_addr, sram_a;
	sd_lba_t       sd_lba;
	sav_size_t     last;
	int unsigned   cyc;
	int unsigned   kind;

	nes_io_top nes_io_top_i (.*);

	`include "tb_nes_io_checks.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (reset_nes) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// A, B, select, start, up, down, left, right from bit 0 up
	function automatic pad_bits_t model_pad(input joy_word_t j, input logic turbo);
		return {j[0], j[1], j[2], j[3], j[7], j[6],
			j[5] | (turbo & j[9]), j[4] | (turbo & j[8])};
	endfunction

	function automatic logic turbo_phase_now();
		return (cyc % (1 << TURBO_BITS)) >= (1 << (TURBO_BITS - 1));
	endfunction

	// last sector index sits in bits 20:9 of the size
	function automatic img_size_t small_size(input sav_size_t last_sector);
		return (img_size_t'(last_sector) << 9) | img_size_t'($urandom_range(1, 511));
	endfunction

	function automatic logic active_request(input logic is_write);
		return is_write ? sd_wr : sd_rd;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic read_pads();
		pad_bits_t  sh1;
		pad_bits_t  sh2;
		logic [1:0] mask;
		sh1 = model_pad(joy_swap ? joy_b : joy_a, turbo_phase_now());
		sh2 = model_pad(joy_swap ? joy_a : joy_b, turbo_phase_now());
		joypad_strobe = 1'b1;
		next_cycle();
		joypad_strobe = 1'b0;
		repeat (20) begin
			check_pad("port 1", pad_data_t'(sh1[0]), joypad1_data);
			check_pad("port 2", pad_data_t'(sh2[0]), joypad2_data);
			mask = 2'($urandom_range(1, 3));
			joypad_clock = mask;
			next_cycle();
			joypad_clock = 2'b00;
			next_cycle();
			if (mask[0]) sh1 = sh1 >> 1;
			if (mask[1]) sh2 = sh2 >> 1;
		end
	endtask

	task automatic run_loader_test();
		mem_addr_t m_addr;
		mem_byte_t m_data;
		logic      m_pending;
		logic      m_we;
		logic      m_valid;
		int        i;
		start_test("loader staging");
		m_pending = 1'b0;
		m_we = 1'b0;
		m_valid = 1'b0;
		nes_ce = nes_phase_t'($urandom_range(0, 3));
		if ($urandom_range(0, 1) != 0) downloading = 1'b1;
		else loader_busy = 1'b1;
		for (i = 0; i < 160 || m_pending || m_we; i++) begin
			loader_write = 1'b0;
			cpu_addr = mem_addr_t'($urandom);
			cpu_dout = mem_byte_t'($urandom);
			cpu_read = $urandom_range(0, 1) != 0;
			if (i < 160 && !m_pending && !m_we && nes_ce != MEM_PHASE
					&& $urandom_range(0, 3) == 0) begin
				loader_write = 1'b1;
				loader_addr = mem_addr_t'($urandom);
				loader_data = mem_byte_t'($urandom);
			end
			// staged write leaves in the memory phase
			if (nes_ce == MEM_PHASE) begin
				m_we = m_pending;
				m_pending = 1'b0;
			end
			if (loader_write) begin
				m_pending = 1'b1;
				m_addr = loader_addr;
				m_data = loader_data;
				m_valid = 1'b1;
			end
			next_cycle();
			check_bit("mem_we in window", m_we, mem_we);
			check_bit("mem_oe in window", 1'b0, mem_oe);
			if (m_valid) check_mem("loader bus", m_addr, m_data, mem_addr, mem_din);
			nes_ce = nes_ce + 2'd1;
		end
		loader_write = 1'b0;
		downloading = 1'b0;
		loader_busy = 1'b0;
		repeat (40) begin
			cpu_addr = mem_addr_t'($urandom);
			cpu_dout = mem_byte_t'($urandom);
			cpu_read = $urandom_range(0, 1) != 0;
			cpu_write = $urandom_range(0, 1) != 0;
			#1;
			check_mem("cpu bus", cpu_addr, cpu_dout, mem_addr, mem_din);
			check_bit("mem_oe", cpu_read, mem_oe);
			check_bit("mem_we", cpu_write, mem_we);
			next_cycle();
		end
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		end_test();
	endtask

	task automatic mount_image(input img_size_t size);
		img_size = size;
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
		next_cycle();
	endtask

	// plays the sd controller, one sector per request
	task automatic serve_sectors(input logic is_write, input sav_size_t last_sector);
		int unsigned s;
		int unsigned wait_cnt;
		for (s = 0; s <= 32'(last_sector); s++) begin
			wait_cnt = 0;
			while (active_request(is_write) !== 1'b1 && wait_cnt < 64) begin
				next_cycle();
				wait_cnt++;
			end
			if (wait_cnt == 64) begin
				report_error($sformatf("no sd request came for sector %0d", s));
				return;
			end
			check_lba("sector", sd_lba_t'(s), sd_lba);
			check_bit("other request", 1'b0, active_request(!is_write));
			repeat ($urandom_range(0, 4)) begin
				next_cycle();
				check_bit("request held", 1'b1, active_request(is_write));
			end
			sd_ack = 1'b1;
			next_cycle();
			check_bit("request dropped on ack", 1'b0, active_request(is_write));
			repeat ($urandom_range(0, 3)) next_cycle();
			sd_ack = 1'b0;
			next_cycle();
		end
		repeat (16) begin
			check_bit("no request after last sector", 1'b0, sd_rd | sd_wr);
			next_cycle();
		end
	endtask

	initial begin
		void'($urandom(32'hb97d));
		reset_nes = 1'b1;
		{joy_swap, joypad_strobe, joypad_clock, joy_a, joy_b} = '0;
		{downloading, loader_busy, loader_write, loader_addr, loader_data, nes_ce} = '0;
		{cpu_addr, cpu_dout, cpu_read, cpu_write} = '0;
		{img_mounted, img_size, bk_save, sd_ack, sd_buff_wr, sd_buff_rd, sd_buff_addr} = '0;
		model_req = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset_nes = 1'b0;

		start_test("pad readout");
		repeat (8) begin
			joy_a = joy_word_t'($urandom);
			joy_b = joy_word_t'($urandom);
			read_pads();
		end
		end_test();

		start_test("swap");
		joy_swap = 1'b1;
		repeat (8) begin
			joy_a = joy_word_t'($urandom);
			joy_b = joy_word_t'($urandom);
			read_pads();
		end
		joy_swap = 1'b0;
		end_test();

		run_loader_test();

		start_test("backup load");
		repeat (3) begin
			last = sav_size_t'($urandom_range(0, 6));
			mount_image(small_size(last));
			check_bit("bk_ena after mount", 1'b1, bk_ena);
			check_bit("load starts", 1'b1, sd_rd);
			serve_sectors(1'b0, last);
		end
		mount_image('0);
		check_bit("bk_ena after empty mount", 1'b0, bk_ena);
		repeat (8) begin
			check_bit("no load after empty mount", 1'b0, sd_rd);
			next_cycle();
		end
		end_test();

		start_test("backup save and buffer");
		last = sav_size_t'($urandom_range(0, 6));
		mount_image(small_size(last));
		serve_sectors(1'b0, last);
		repeat (2) begin
			bk_save = 1'b1;
			next_cycle();
			bk_save = 1'b0;
			serve_sectors(1'b1, last);
		end
		repeat (24) begin
			kind = $urandom_range(0, 2);
			sd_buff_wr = kind == 1;
			sd_buff_rd = kind == 2;
			sd_buff_addr = sd_buff_addr_t'($urandom);
			next_cycle();
			if (kind != 0) begin
				model_req = ~model_req;
				check_bit("sram_we", sd_buff_wr, sram_we);
				check_buf_addr("sram_a", sd_buff_addr, sram_a);
			end
			check_bit("sram_req", model_req, sram_req);
		end
		{sd_buff_wr, sd_buff_rd} = 2'b00;
		end_test();

		// X on pad A and Y on pad B only
		start_test("turbo");
		joy_a = 32'h0000_0100;
		joy_b = 32'h0000_0200;
		read_pads();
		while (cyc < TURBO_WAIT + 16) next_cycle();
		read_pads();
		end_test();

		$display("summary: %0d tests run, %0d with errors, %0d check errors",
			tests_run, tests_with_errors, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/nes_io_top.sv
// ============================================================
// nes board glue logic
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module nes_io_top (
	input  wire                           clk,
	input  wire                           reset_nes,
	// joysticks
	input  wire                           joy_swap,
	input  wire nes_input_pkg::joy_word_t   joy_a,
	input  wire nes_input_pkg::joy_word_t   joy_b,
	input  wire                           joypad_strobe,
	input  wire [1:0]                     joypad_clock,
	output nes_input_pkg::pad_data_t      joypad1_data,
	output nes_input_pkg::pad_data_t      joypad2_data,
	// loader and cpu bus
	input  wire                           downloading,
	input  wire                           loader_busy,
	input  wire                           loader_write,
	input  wire nes_mem_pkg::mem_addr_t     loader_addr,
	input  wire nes_mem_pkg::mem_byte_t     loader_data,
	input  wire nes_mem_pkg::nes_phase_t    nes_ce,
	input  wire nes_mem_pkg::mem_addr_t     cpu_addr,
	input  wire nes_mem_pkg::mem_byte_t     cpu_dout,
	input  wire                           cpu_read,
	input  wire                           cpu_write,
	output nes_mem_pkg::mem_addr_t        mem_addr,
	output nes_mem_pkg::mem_byte_t        mem_din,
	output logic                          mem_we,
	output logic                          mem_oe,
	// save ram backup
	input  wire                           img_mounted,
	input  wire nes_mem_pkg::img_size_t     img_size,
	input  wire                           bk_save,
	input  wire                           sd_ack,
	input  wire                           sd_buff_wr,
	input  wire                           sd_buff_rd,
	input  wire nes_mem_pkg::sd_buff_addr_t sd_buff_addr,
	output nes_mem_pkg::sd_lba_t          sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_ena,
	output logic                          sram_req,
	output logic                          sram_we,
	output nes_mem_pkg::sd_buff_addr_t    sram_a
);
	import nes_input_pkg::*;

	pad_bits_t nes_pad_a;
	pad_bits_t nes_pad_b;

	pad_mapper pad_mapper_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.joy_swap  (joy_swap),
		.joy_a     (joy_a),
		.joy_b     (joy_b),
		.nes_pad_a (nes_pad_a),
		.nes_pad_b (nes_pad_b)
	);

	joypad_port joypad_port_i (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.nes_pad_a     (nes_pad_a),
		.nes_pad_b     (nes_pad_b),
		.joypad1_data  (joypad1_data),
		.joypad2_data  (joypad2_data)
	);

	loader_write_stage loader_write_stage_i (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.downloading  (downloading),
		.loader_busy  (loader_busy),
		.loader_write (loader_write),
		.loader_addr  (loader_addr),
		.loader_data  (loader_data),
		.nes_ce       (nes_ce),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.cpu_read     (cpu_read),
		.cpu_write    (cpu_write),
		.mem_addr     (mem_addr),
		.mem_din      (mem_din),
		.mem_we       (mem_we),
		.mem_oe       (mem_oe)
	);

	backup_ram_ctrl backup_ram_ctrl_i (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.img_mounted  (img_mounted),
		.downloading  (downloading),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.img_size     (img_size),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_rd   (sd_buff_rd),
		.sd_buff_addr (sd_buff_addr),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_ena       (bk_ena),
		.sram_req     (sram_req),
		.sram_we      (sram_we),
		.sram_a       (sram_a)
	);

endmodule

`default_nettype wire

//--- logic/backup_ram_ctrl.sv
// ============================================================
// save ram backup sequencer
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module backup_ram_ctrl (
	input  wire                           clk,
	input  wire                           reset_nes,
	input  wire                           img_mounted,
	input  wire                           downloading,
	input  wire                           bk_save,
	input  wire                           sd_ack,
	input  wire nes_mem_pkg::img_size_t     img_size,
	input  wire                           sd_buff_wr,
	input  wire                           sd_buff_rd,
	input  wire nes_mem_pkg::sd_buff_addr_t sd_buff_addr,
	output nes_mem_pkg::sd_lba_t          sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_ena,
	output logic                          sram_req,
	output logic                          sram_we,
	output nes_mem_pkg::sd_buff_addr_t    sram_a
);
	import nes_mem_pkg::*;

	backup_state_t state;
	sav_size_t     sav_size;
	logic          bk_load;
	logic          bk_loading;
	logic          mounted_d;
	logic          downloading_d;
	logic          bk_save_d;
	logic          sd_ack_d;
	logic          last_sector;

	assign last_sector = (sd_lba[$bits(sav_size_t)-1:0] == sav_size);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= backup_idle;
			bk_ena        <= 1'b0;
			bk_load       <= 1'b0;
			bk_loading    <= 1'b0;
			sd_lba        <= '0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			mounted_d     <= 1'b0;
			downloading_d <= 1'b0;
			bk_save_d     <= 1'b0;
			sd_ack_d      <= 1'b0;
		end else begin
			mounted_d     <= img_mounted;
			downloading_d <= downloading;
			bk_save_d     <= bk_save;
			sd_ack_d      <= sd_ack;

			// new image mounted, empty image disables backup
			bk_load <= 1'b0;
			if (img_mounted && !mounted_d) begin
				if (|img_size) begin
					bk_ena   <= 1'b1;
					sav_size <= img_size[SAV_SIZE_MSB:SAV_SIZE_LSB];
					bk_load  <= 1'b1;
				end else begin
					bk_ena <= 1'b0;
				end
			end
			// a new rom download invalidates the save file
			if (downloading && !downloading_d) begin
				bk_ena <= 1'b0;
			end

			// controller took the request
			if (sd_ack && !sd_ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				backup_idle: begin
					if (bk_ena && (bk_load || (bk_save && !bk_save_d))) begin
						state      <= backup_busy;
						sd_lba     <= '0;
						bk_loading <= bk_load;
						sd_rd      <= bk_load;
						sd_wr      <= ~bk_load;
					end
				end
				backup_busy: begin
					// sector done
					if (sd_ack_d && !sd_ack) begin
						if (last_sector) begin
							state      <= backup_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= backup_idle;
			endcase
		end
	end

	// toggle request towards the sd buffer ram
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			sram_req <= 1'b0;
		end else if (sd_buff_wr || sd_buff_rd) begin
			sram_req <= ~sram_req;
		end
	end

	always_ff @(posedge clk) begin
		if (sd_buff_wr || sd_buff_rd) begin
			sram_we <= sd_buff_wr;
			sram_a  <= sd_buff_addr;
		end
	end

endmodule

`default_nettype wire

//--- logic/loader_write_stage.sv
// ============================================================
// loader write staging and cpu bus mux
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module loader_write_stage (
	input  wire                        clk,
	input  wire                        reset_nes,
	input  wire                        downloading,
	input  wire                        loader_busy,
	input  wire                        loader_write,
	input  wire nes_mem_pkg::mem_addr_t  loader_addr,
	input  wire nes_mem_pkg::mem_byte_t  loader_data,
	input  wire nes_mem_pkg::nes_phase_t nes_ce,
	input  wire nes_mem_pkg::mem_addr_t  cpu_addr,
	input  wire nes_mem_pkg::mem_byte_t  cpu_dout,
	input  wire                        cpu_read,
	input  wire                        cpu_write,
	output nes_mem_pkg::mem_addr_t     mem_addr,
	output nes_mem_pkg::mem_byte_t     mem_din,
	output logic                       mem_we,
	output logic                       mem_oe
);
	import nes_mem_pkg::*;

	mem_addr_t addr_q;
	mem_byte_t data_q;
	logic      write_pending;
	logic      loader_we;
	logic      load_window;

	// captured byte waits here for its memory slot
	always_ff @(posedge clk) begin
		if (loader_write) begin
			addr_q <= loader_addr;
			data_q <= loader_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			write_pending <= 1'b0;
			loader_we     <= 1'b0;
		end else begin
			if (loader_write) begin
				write_pending <= 1'b1;
			end
			// we is updated once per phase round, so it lasts four cycles
			if (nes_ce == MEM_PHASE) begin
				loader_we <= write_pending;
				if (write_pending) begin
					write_pending <= 1'b0;
				end
			end
		end
	end

	assign load_window = downloading | loader_busy;

	// loader owns the bus for the whole load
	assign mem_addr = load_window ? addr_q : cpu_addr;
	assign mem_din  = load_window ? data_q : cpu_dout;
	assign mem_we   = loader_we | cpu_write;
	assign mem_oe   = ~load_window & cpu_read;

endmodule

`default_nettype wire

//--- logic/joypad_port.sv
// ============================================================
// nes controller ports
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module joypad_port (
	input  wire                       clk,
	input  wire                       reset_nes,
	input  wire                       joypad_strobe,
	input  wire [1:0]                 joypad_clock,
	input  wire nes_input_pkg::pad_bits_t nes_pad_a,
	input  wire nes_input_pkg::pad_bits_t nes_pad_b,
	output nes_input_pkg::pad_data_t  joypad1_data,
	output nes_input_pkg::pad_data_t  joypad2_data
);
	import nes_input_pkg::*;

	pad_bits_t            shift_q [JOY_PORTS];
	logic [JOY_PORTS-1:0] clock_d;
	logic [JOY_PORTS-1:0] clock_fall;

	assign clock_fall = clock_d & ~joypad_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q[0] <= '0;
			shift_q[1] <= '0;
			clock_d    <= '0;
		end else begin
			// strobe held high keeps reloading
			if (joypad_strobe) begin
				shift_q[0] <= nes_pad_a;
				shift_q[1] <= nes_pad_b;
			end
			// next button on the falling edge of each port clock
			for (int i = 0; i < JOY_PORTS; i++) begin
				if (clock_fall[i]) begin
					shift_q[i] <= shift_q[i] >> 1;
				end
			end
			clock_d <= joypad_clock;
		end
	end

	// only D0 is wired, the upper lines read zero
	assign joypad1_data = pad_data_t'(shift_q[0][0]);
	assign joypad2_data = pad_data_t'(shift_q[1][0]);

endmodule

`default_nettype wire

//--- logic/pad_mapper.sv
// ============================================================
// joystick to nes pad mapping
// ============================================================
`default_nettype none
`timescale 1ns/10ps

module pad_mapper (
	input  wire                       clk,
	input  wire                       reset_nes,
	input  wire                       joy_swap,
	input  wire nes_input_pkg::joy_word_t joy_a,
	input  wire nes_input_pkg::joy_word_t joy_b,
	output nes_input_pkg::pad_bits_t  nes_pad_a,
	output nes_input_pkg::pad_bits_t  nes_pad_b
);
	import nes_input_pkg::*;

	logic [TURBO_BITS-1:0] turbo_cnt;
	logic                  turbo_phase;
	joy_word_t             joy_p1;
	joy_word_t             joy_p2;

	// X and Y fire A and B while the phase bit is high
	function automatic pad_bits_t map_pad(input joy_word_t joy, input logic turbo);
		pad_bits_t pad;
		pad[0] = joy[JOY_A] | (turbo & joy[JOY_TURBO_A]);
		pad[1] = joy[JOY_B] | (turbo & joy[JOY_TURBO_B]);
		pad[2] = joy[JOY_SELECT];
		pad[3] = joy[JOY_START];
		pad[4] = joy[JOY_UP];
		pad[5] = joy[JOY_DOWN];
		pad[6] = joy[JOY_LEFT];
		pad[7] = joy[JOY_RIGHT];
		return pad;
	endfunction

	// free running, roughly 20 Hz at the core clock
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			turbo_cnt <= '0;
		end else begin
			turbo_cnt <= turbo_cnt + 1'b1;
		end
	end

	assign turbo_phase = turbo_cnt[TURBO_BITS-1];

	assign joy_p1 = joy_swap ? joy_b : joy_a;
	assign joy_p2 = joy_swap ? joy_a : joy_b;

	assign nes_pad_a = map_pad(joy_p1, turbo_phase);
	assign nes_pad_b = map_pad(joy_p2, turbo_phase);

endmodule

`default_nettype wire

//--- logic/nes_mem_pkg.sv
// ============================================================
// memory bus and backup ram types
// ============================================================
`default_nettype none

package nes_mem_pkg;

	// cpu side memory bus
	typedef logic [21:0] mem_addr_t;
	typedef logic [7:0]  mem_byte_t;

	// nes clock enable phase
	typedef logic [1:0]  nes_phase_t;

	// staged loader writes go out here
	localparam nes_phase_t MEM_PHASE = 2'd3;

	// sd card side
	typedef logic [31:0] sd_lba_t;
	typedef logic [31:0] img_size_t;
	typedef logic [8:0]  sd_buff_addr_t;

	// last sector index of the save image
	typedef logic [11:0] sav_size_t;

	// sav_size_t is taken from these image size bits
	localparam int SAV_SIZE_LSB = 9;
	localparam int SAV_SIZE_MSB = 20;

	typedef enum logic {
		backup_idle,
		backup_busy
	} backup_state_t;

endpackage

`default_nettype wire

//--- logic/nes_input_pkg.sv
// ============================================================
// joystick and joypad port types
// ============================================================
`default_nettype none

package nes_input_pkg;

	// raw joystick word from the io controller
	typedef logic [31:0] joy_word_t;
	// buttons in nes shift order, A in bit 0
	typedef logic [7:0]  pad_bits_t;
	// value the cpu reads from $4016/$4017
	typedef logic [4:0]  pad_data_t;

	localparam int TURBO_BITS = 20;
	localparam int JOY_PORTS  = 2;

	// bit positions inside joy_word_t
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_A       = 4;
	localparam int JOY_B       = 5;
	localparam int JOY_SELECT  = 6;
	localparam int JOY_START   = 7;
	localparam int JOY_TURBO_A = 8;
	localparam int JOY_TURBO_B = 9;

endpackage

`default_nettype wire
